//--- Makefile
TOP = tb_pipe_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
src/pipe_pkg.sv
src/sync_fifo.sv
src/host_pipe_bridge.sv
src/dma_port.sv
src/burst_mem.sv
src/pipe_top.sv
testbench/tb_clock.sv
testbench/pipe_top_properties.sv
testbench/tb_pipe_top.sv

//--- src/burst_mem.sv
`timescale 1ns/10ps

module burst_mem import pipe_pkg::*; (
	input  logic     okClk,
	input  logic     rst,
	input  logic     cmd_en,
	input  mem_cmd_t cmd,
	input  logic     wr_en,
	input  word_t    wr_data,
	input  logic     rd_en,
	output logic     cmd_full,
	output logic     wr_full,
	output word_t    rd_data,
	output logic     rd_empty
);

	mem_cmd_t   cq_dout;
	logic       cq_empty;
	logic       cq_pop;
	word_t      wq_dout;
	count_t     wq_count;
	logic       wq_pop;
	word_t      rq_din;
	count_t     rq_count;
	logic       rq_push;
	word_t      mem [MEM_WORDS];
	logic       busy;
	mem_instr_t cur_instr;
	mem_addr_t  cur_addr;
	count_t     left;       // words still to move in this burst
	logic       start_ok;

	sync_fifo #(.payload_t(mem_cmd_t)) cmd_q (
		.okClk (okClk), .rst (rst), .push (cmd_en), .din (cmd), .pop (cq_pop),
		.dout (cq_dout), .empty (cq_empty), .full (cmd_full), .count ()
	);
	sync_fifo #(.payload_t(word_t)) wr_q (
		.okClk (okClk), .rst (rst), .push (wr_en), .din (wr_data), .pop (wq_pop),
		.dout (wq_dout), .empty (), .full (wr_full), .count (wq_count)
	);
	sync_fifo #(.payload_t(word_t)) rd_q (
		.okClk (okClk), .rst (rst), .push (rq_push), .din (rq_din), .pop (rd_en),
		.dout (rd_data), .empty (rd_empty), .full (), .count (rq_count)
	);

	// a burst starts only once it can run one word per cycle to the end
	assign start_ok = !busy && !cq_empty && ((cq_dout.instr == MEM_WRITE)
		? (wq_count >= cq_dout.bl)
		: (FIFO_DEPTH - int'(rq_count) >= int'(cq_dout.bl)));
	assign cq_pop  = start_ok;
	assign wq_pop  = busy && (cur_instr == MEM_WRITE);
	assign rq_push = busy && (cur_instr == MEM_READ);
	assign rq_din  = mem[cur_addr];

	always_ff @(posedge okClk) begin
		if (rst) begin
			busy      <= 1'b0;
			cur_instr <= MEM_WRITE;
			cur_addr  <= '0;
			left      <= '0;
		end else if (start_ok) begin
			busy      <= 1'b1;
			cur_instr <= cq_dout.instr;
			cur_addr  <= cq_dout.addr;
			left      <= cq_dout.bl;
		end else if (busy) begin
			cur_addr <= cur_addr + 1'b1;    // wraps at MEM_WORDS
			left     <= left - 1'b1;
			if (left == count_t'(1))
				busy <= 1'b0;               // last word of the burst
		end
	end

	always_ff @(posedge okClk) begin
		if (wq_pop)
			mem[cur_addr] <= wq_dout;
	end

endmodule

//--- src/dma_port.sv
`timescale 1ns/10ps

module dma_port import pipe_pkg::*; (
	input  logic     okClk,
	input  logic     rst,
	input  logic     writes_en,
	input  logic     reads_en,
	input  word_t    in_data,
	input  count_t   in_count,
	input  logic     in_empty,
	input  count_t   out_count,
	input  logic     cmd_full,
	input  logic     wr_full,
	input  word_t    rd_data,
	input  logic     rd_empty,
	output logic     in_pop,
	output logic     out_push,
	output word_t    out_data,
	output logic     cmd_en,
	output mem_cmd_t cmd,
	output logic     wr_en,
	output word_t    wr_data,
	output logic     rd_en
);

	typedef enum logic [1:0] {
		IDLE,
		WRITE_DATA,
		WRITE_CMD
	} state_t;

	state_t    state;
	state_t    state_nxt;
	mem_addr_t wr_addr;
	mem_addr_t rd_addr;
	mem_addr_t fill;        // words in memory not yet read back
	count_t    beat;
	count_t    in_flight;   // read words commanded but not in pipe-out
	logic      wr_go;
	logic      rd_go;
	logic      rd_issue;
	logic      beat_move;

	assign fill  = wr_addr - rd_addr;
	assign wr_go = writes_en && int'(in_count) >= BURST_LEN && int'(fill) <= MEM_WORDS - BURST_LEN;
	assign rd_go = reads_en && int'(fill) >= BURST_LEN
		&& FIFO_DEPTH - int'(out_count) - int'(in_flight) >= BURST_LEN;

	// --------------------
	// write burst path
	// --------------------
	assign beat_move = (state == WRITE_DATA) && !in_empty && !wr_full;
	assign in_pop    = beat_move;
	assign wr_en     = beat_move;
	assign wr_data   = in_data;

	always_comb begin
		state_nxt = state;
		rd_issue  = 1'b0;
		cmd_en    = 1'b0;
		cmd.instr = MEM_WRITE;
		cmd.addr  = wr_addr;
		cmd.bl    = count_t'(BURST_LEN);
		case (state)
			IDLE: begin
				if (wr_go) begin
					state_nxt = WRITE_DATA;
				end else if (rd_go && !cmd_full) begin
					rd_issue  = 1'b1;       // reads go out straight from idle
					cmd_en    = 1'b1;
					cmd.instr = MEM_READ;
					cmd.addr  = rd_addr;
				end
			end
			WRITE_DATA: begin
				if (beat_move && beat == count_t'(BURST_LEN - 1))
					state_nxt = WRITE_CMD;
			end
			WRITE_CMD: begin
				if (!cmd_full) begin
					cmd_en    = 1'b1;
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge okClk) begin
		if (rst) begin
			state     <= IDLE;
			wr_addr   <= '0;
			rd_addr   <= '0;
			beat      <= '0;
			in_flight <= '0;
		end else begin
			state <= state_nxt;
			if (beat_move)
				beat <= (beat == count_t'(BURST_LEN - 1)) ? '0 : beat + 1'b1;
			if (state == WRITE_CMD && cmd_en)
				wr_addr <= wr_addr + mem_addr_t'(BURST_LEN);     // wraps modulo MEM_WORDS
			if (rd_issue)
				rd_addr <= rd_addr + mem_addr_t'(BURST_LEN);
			in_flight <= in_flight + (rd_issue ? count_t'(BURST_LEN) : '0)
				- (out_push ? count_t'(1) : '0);
		end
	end

	// --------------------
	// read drain, always on
	// --------------------
	assign rd_en    = !rd_empty && (out_count != count_t'(FIFO_DEPTH));
	assign out_push = rd_en;
	assign out_data = rd_data;

endmodule

//--- src/host_pipe_bridge.sv
`timescale 1ns/10ps

module host_pipe_bridge import pipe_pkg::*; (
	input  logic   okClk,
	input  logic   rst,
	input  logic   pi_write,
	input  word_t  pi_data,
	input  logic   po_read,
	input  logic   in_pop,
	input  logic   out_push,
	input  word_t  out_data,
	output logic   pi_ready,
	output logic   po_ready,
	output word_t  po_data,
	output word_t  in_data,
	output count_t in_count,
	output logic   in_empty,
	output count_t out_count
);

	// host writes here, DMA drains
	sync_fifo #(.payload_t(word_t)) pipe_in_fifo (
		.okClk (okClk),
		.rst   (rst),
		.push  (pi_write),
		.din   (pi_data),
		.pop   (in_pop),
		.dout  (in_data),
		.empty (in_empty),
		.full  (),
		.count (in_count)
	);

	// DMA fills from memory, host reads
	sync_fifo #(.payload_t(word_t)) pipe_out_fifo (
		.okClk (okClk),
		.rst   (rst),
		.push  (out_push),
		.din   (out_data),
		.pop   (po_read),
		.dout  (po_data),
		.empty (),
		.full  (),
		.count (out_count)
	);

	// --------------------
	// block throttle
	// --------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			pi_ready <= 1'b0;
			po_ready <= 1'b0;
		end else begin
			pi_ready <= (int'(in_count) <= FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE);  // room for a block
			po_ready <= (int'(out_count) >= BLOCK_SIZE);    // a whole block waits
		end
	end

endmodule

//--- src/pipe_pkg.sv
package pipe_pkg;

	// --------------------
	// sizes
	// --------------------
	localparam int WORD_BITS       = 32;
	localparam int FIFO_DEPTH      = 64;     // every sync_fifo
	localparam int BLOCK_SIZE      = 16;     // host transfer block in words
	localparam int BUFFER_HEADROOM = 4;      // slack for the registered ready flag
	localparam int BURST_LEN       = 8;      // words per memory burst
	localparam int MEM_WORDS       = 256;    // addresses wrap at this size

	// --------------------
	// types
	// --------------------
	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [7:0]           mem_addr_t;   // word address
	typedef logic [6:0]           count_t;      // 0 to FIFO_DEPTH

	typedef enum logic {
		MEM_WRITE = 1'b0,
		MEM_READ  = 1'b1
	} mem_instr_t;

	// one memory command
	typedef struct packed {
		mem_instr_t instr;
		mem_addr_t  addr;
		count_t     bl;          // burst length in words
	} mem_cmd_t;

endpackage

//--- src/pipe_top.sv
`timescale 1ns/10ps

module pipe_top import pipe_pkg::*; (
	input  logic  okClk,
	input  logic  rst,
	input  logic  pi_write,
	input  word_t pi_data,
	input  logic  writes_en,
	input  logic  reads_en,
	input  logic  po_read,
	output logic  pi_ready,
	output logic  po_ready,
	output word_t po_data
);

	// --------------------
	// bridge to DMA
	// --------------------
	word_t    in_data;
	count_t   in_count;
	logic     in_empty;
	logic     in_pop;
	count_t   out_count;
	logic     out_push;
	word_t    out_data;

	// --------------------
	// DMA to memory port
	// --------------------
	logic     cmd_en;
	mem_cmd_t cmd;
	logic     cmd_full;
	logic     wr_en;
	word_t    wr_data;
	logic     wr_full;
	logic     rd_en;
	word_t    rd_data;
	logic     rd_empty;

	host_pipe_bridge bridge (
		.okClk     (okClk),
		.rst       (rst),
		.pi_write  (pi_write),
		.pi_data   (pi_data),
		.po_read   (po_read),
		.in_pop    (in_pop),
		.out_push  (out_push),
		.out_data  (out_data),
		.pi_ready  (pi_ready),
		.po_ready  (po_ready),
		.po_data   (po_data),
		.in_data   (in_data),
		.in_count  (in_count),
		.in_empty  (in_empty),
		.out_count (out_count)
	);

	dma_port dma_p0 (
		.okClk     (okClk),
		.rst       (rst),
		.writes_en (writes_en),     // host level, gates write bursts
		.reads_en  (reads_en),      // host level, gates read bursts
		.in_data   (in_data),
		.in_count  (in_count),
		.in_empty  (in_empty),
		.out_count (out_count),
		.cmd_full  (cmd_full),
		.wr_full   (wr_full),
		.rd_data   (rd_data),
		.rd_empty  (rd_empty),
		.in_pop    (in_pop),
		.out_push  (out_push),
		.out_data  (out_data),
		.cmd_en    (cmd_en),
		.cmd       (cmd),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.rd_en     (rd_en)
	);

	burst_mem mem_p0 (
		.okClk    (okClk),
		.rst      (rst),
		.cmd_en   (cmd_en),
		.cmd      (cmd),
		.wr_en    (wr_en),
		.wr_data  (wr_data),
		.rd_en    (rd_en),
		.cmd_full (cmd_full),
		.wr_full  (wr_full),
		.rd_data  (rd_data),
		.rd_empty (rd_empty)
	);

endmodule

//--- src/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo import pipe_pkg::*; #(
	parameter type payload_t = word_t
) (
	input  logic     okClk,
	input  logic     rst,
	input  logic     push,
	input  payload_t din,
	input  logic     pop,
	output payload_t dout,
	output logic     empty,
	output logic     full,
	output count_t   count
);

	localparam int PTR_BITS = $clog2(FIFO_DEPTH);

	payload_t            buffer [FIFO_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic                do_push;
	logic                do_pop;

	assign empty   = (count == '0);
	assign full    = (count == count_t'(FIFO_DEPTH));
	assign do_push = push && !full;     // push on full is dropped
	assign do_pop  = pop && !empty;     // pop on empty is ignored
	assign dout    = buffer[rd_ptr];    // head word shows without a pop

	// --------------------
	// pointers and count
	// --------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;    // wraps at FIFO_DEPTH
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge okClk) begin
		if (do_push)
			buffer[wr_ptr] <= din;
	end

endmodule

//--- testbench/pipe_input.txt
// one 32-bit hex word per line, streamed in order through the pipe
// four blocks of 16 words, the low byte counts 00 to 3f
1a2b3c00
1a2b3c01
1a2b3c02
1a2b3c03
1a2b3c04
1a2b3c05
1a2b3c06
1a2b3c07
1a2b3c08
1a2b3c09
1a2b3c0a
1a2b3c0b
1a2b3c0c
1a2b3c0d
1a2b3c0e
1a2b3c0f
4d5e6f10
4d5e6f11
4d5e6f12
4d5e6f13
4d5e6f14
4d5e6f15
4d5e6f16
4d5e6f17
4d5e6f18
4d5e6f19
4d5e6f1a
4d5e6f1b
4d5e6f1c
4d5e6f1d
4d5e6f1e
4d5e6f1f
70819220
70819221
70819222
70819223
70819224
70819225
70819226
70819227
70819228
70819229
7081922a
7081922b
7081922c
7081922d
7081922e
7081922f
a3b4c530
a3b4c531
a3b4c532
a3b4c533
a3b4c534
a3b4c535
a3b4c536
a3b4c537
a3b4c538
a3b4c539
a3b4c53a
a3b4c53b
a3b4c53c
a3b4c53d
a3b4c53e
a3b4c53f

//--- testbench/pipe_top_properties.sv
`timescale 1ns/10ps

module pipe_top_properties import pipe_pkg::*; (
	input logic     okClk,
	input logic     rst,
	input logic     cmd_en,
	input mem_cmd_t cmd,
	input logic     wr_en,
	input logic     in_pop,
	input logic     in_empty,
	input count_t   in_count,
	input logic     out_push,
	input count_t   out_count,
	input count_t   in_flight
);

	count_t burst_words;    // words sent to the write queue since the last write command

	always_ff @(posedge okClk) begin
		if (rst)
			burst_words <= '0;
		else if (cmd_en && cmd.instr == MEM_WRITE)
			burst_words <= '0;
		else if (wr_en)
			burst_words <= burst_words + 1'b1;
	end

	// every memory command is one fixed-length burst, write data already queued
	burst_len_fixed: assert property (@(posedge okClk) disable iff (rst)
		cmd_en |-> (cmd.bl == count_t'(BURST_LEN)
			&& (cmd.instr == MEM_READ || burst_words == cmd.bl)))
		else $error("memory command with burst length %0d after %0d write words",
			cmd.bl, burst_words);

	// a write burst starts only with the whole burst waiting in pipe-in
	no_pop_when_empty: assert property (@(posedge okClk) disable iff (rst)
		in_pop |-> (!in_empty && int'(in_count) + int'(burst_words) >= BURST_LEN))
		else $error("pipe-in FIFO ran short during a write burst");

	// read bursts never overbook the pipe-out FIFO
	no_push_when_full: assert property (@(posedge okClk) disable iff (rst)
		out_push |-> (int'(out_count) + int'(in_flight) <= FIFO_DEPTH))
		else $error("pipe-out FIFO pushed beyond its free space");

endmodule

bind dma_port pipe_top_properties dma_checks (
	.okClk     (okClk),
	.rst       (rst),
	.cmd_en    (cmd_en),
	.cmd       (cmd),
	.wr_en     (wr_en),
	.in_pop    (in_pop),
	.in_empty  (in_empty),
	.in_count  (in_count),
	.out_push  (out_push),
	.out_count (out_count),
	.in_flight (in_flight)
);

//--- testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic okClk,
	output logic rst
);

	initial okClk = 1'b0;
	always #2 okClk = ~okClk;    // 4 ns period

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge okClk);
		#1 rst = 1'b0;           // released just past the third edge
	end

endmodule

//--- testbench/tb_pipe_top.sv
`timescale 1ns/10ps

module tb_pipe_top import pipe_pkg::*; ();

	localparam int WORD_COUNT     = 64;    // four host blocks
	localparam int FIRST_FILL     = 45;    // one past the pi_ready limit
	localparam int QUIET_CYCLES   = 200;
	localparam int TAIL_CYCLES    = 40;
	localparam int TIMEOUT_CYCLES = 30 * WORD_COUNT + 300;

	logic        okClk;
	logic        rst;
	logic        pi_write;
	word_t       pi_data;
	logic        writes_en;
	logic        reads_en;
	logic        po_read;
	logic        pi_ready;
	logic        po_ready;
	word_t       po_data;

	word_t       words [WORD_COUNT];      // stimulus, also the expected read order
	int          wr_idx;
	int          rd_idx;
	int          error_count;
	int unsigned cycle_count;

	tb_clock clock_gen (
		.okClk (okClk),
		.rst   (rst)
	);

	pipe_top UUT (
		.okClk     (okClk),
		.rst       (rst),
		.pi_write  (pi_write),
		.pi_data   (pi_data),
		.writes_en (writes_en),
		.reads_en  (reads_en),
		.po_read   (po_read),
		.pi_ready  (pi_ready),
		.po_ready  (po_ready),
		.po_data   (po_data)
	);

	// --------------------
	// helpers
	// --------------------
	task automatic stop_run;
		$display("Test failures found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("FAIL at %0d ns: %s = %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic step;
		@(posedge okClk);
		#1;                               // drive and sample just past the edge
	endtask

	task automatic write_word;
		int unsigned gap;
		gap = $urandom % 4;                // idle cycles before the strobe
		repeat (gap) step();
		pi_write = 1'b1;
		pi_data  = words[wr_idx];
		step();
		pi_write = 1'b0;
		wr_idx++;
	endtask

	// one block per pi_ready, like the host
	task automatic write_blocks;
		int n;
		while (wr_idx < WORD_COUNT) begin
			if (pi_ready) begin
				for (n = 0; n < BLOCK_SIZE && wr_idx < WORD_COUNT; n++)
					write_word();
			end else begin
				step();
			end
		end
	endtask

	task automatic read_block;
		int n;
		while (!po_ready)
			step();
		for (n = 0; n < BLOCK_SIZE; n++) begin
			check_value("po_data", po_data, words[rd_idx]);    // head before the pop
			rd_idx++;
			po_read = 1'b1;
			step();
		end
		po_read = 1'b0;
		step();                           // po_ready catches up with the last pop
	endtask

	// --------------------
	// timeout
	// --------------------
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge okClk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		stop_run();
	end

	// --------------------
	// stimulus and checks
	// --------------------
	initial begin
		int i;
		pi_write    = 1'b0;
		pi_data     = '0;
		writes_en   = 1'b0;
		reads_en    = 1'b0;
		po_read     = 1'b0;
		wr_idx      = 0;
		rd_idx      = 0;
		error_count = 0;
		void'($urandom(32'ha3a7));
		for (i = 0; i < WORD_COUNT; i++)
			words[i] = {16'hbad0, 16'(i)};      // marks words the file did not set
		$readmemh("testbench/pipe_input.txt", words);
		if (words[WORD_COUNT-1] === {16'hbad0, 16'(WORD_COUNT-1)}) begin
			$display("stimulus file holds fewer than %0d words", WORD_COUNT);
			stop_run();
		end

		repeat (3) begin                  // reset cycles
			step();
			check_value("pi_ready", pi_ready, 0);
			check_value("po_ready", po_ready, 0);
		end
		step();
		check_value("pi_ready", pi_ready, 1);
		check_value("po_ready", po_ready, 0);

		// fill past the throttle limit, DMA held off
		while (wr_idx < FIRST_FILL) begin
			check_value("pi_ready", pi_ready, 1);
			write_word();
		end
		check_value("pi_ready", pi_ready, 1);    // still shows 44 held
		step();
		check_value("pi_ready", pi_ready, 0);

		repeat (QUIET_CYCLES) begin
			writes_en = 1'($urandom % 2);        // reads stay off
			step();
			check_value("po_ready", po_ready, 0);
		end

		writes_en = 1'b1;
		reads_en  = 1'b1;
		fork
			write_blocks();
			repeat (WORD_COUNT / BLOCK_SIZE) read_block();
		join

		repeat (TAIL_CYCLES) begin        // nothing left behind
			check_value("po_ready", po_ready, 0);
			step();
		end

		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
